// ==== mesh_array.f ====
+incdir+logic
logic/mesh_pkg.sv
logic/mesh_fifo.sv
logic/mesh_router.sv
logic/mesh_bank.sv
logic/mesh_tile.sv
logic/mesh_array.sv
dv/mesh_array_chk.sv
dv/mesh_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mesh testbench with Verilator, run it, and search the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mesh_array_tb \
  -f mesh_array.f -o mesh_sim > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }

./obj_dir/mesh_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== dv/mesh_array_tb.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_array_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mesh_pkg::*;

  localparam int num_stim_lp   = 16;
  localparam int rand_start_lp = 8;   // first entry with random south ready
  localparam int timeout_lp    = 200; // cycles per wait
  localparam int ref_words_lp  = 2 ** (`MESH_X_W + `MESH_Y_W + `MESH_ADDR_W);

  typedef struct packed {
    logic [`MESH_X_W-1:0]    col;
    mesh_op_e                op;
    logic [`MESH_X_W-1:0]    x;
    logic [`MESH_Y_W-1:0]    y;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } stim_s;

  logic                                clk_i;
  logic                                rst_n_i;
  mesh_link_s [E:W][`MESH_Y-1:0]       hor_link_i;
  mesh_link_s [E:W][`MESH_Y-1:0]       hor_link_o;
  logic [E:W][`MESH_Y-1:0]             hor_ready_i;
  logic [E:W][`MESH_Y-1:0]             hor_ready_o;
  mesh_link_s [S:N][`MESH_X-1:0]       ver_link_i;
  mesh_link_s [S:N][`MESH_X-1:0]       ver_link_o;
  logic [S:N][`MESH_X-1:0]             ver_ready_i;
  logic [S:N][`MESH_X-1:0]             ver_ready_o;

  stim_s                   stim_tab [num_stim_lp];
  logic [`MESH_DATA_W-1:0] ref_mem [ref_words_lp]; // {x, y, addr}
  mesh_packet_s            exp_q [$];
  int                      errors;
  int                      num_loads;
  logic                    timed_out;
  logic                    rand_ready;
  integer                  seed = 58;

  mesh_array mesh_array_i (.*);

  bind mesh_array mesh_array_chk link_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ver_out_i   (ver_link_o),
    .ver_ready_i (ver_ready_i),
    .hor_out_i   (hor_link_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic send_entry(input int idx, input stim_s s);
    int           wait_cyc;
    mesh_packet_s exp_pkt;
    wait_cyc = 0;
    ver_link_i[S][s.col] = '{v: 1'b1, pkt: '{op: s.op, dst_x: s.x, dst_y: s.y, src_x: s.col,
                                           src_y: `MESH_Y_W'(`MESH_Y), addr: s.addr,
                                           data: s.data}};
    @(negedge clk_i);
    while (!ver_ready_o[S][s.col] && wait_cyc < timeout_lp)
    begin
      @(negedge clk_i);
      wait_cyc++;
    end
    if (!ver_ready_o[S][s.col])
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: south column %0d never accepted entry %0d", s.col, idx);
    end
    else if (s.op == mesh_op_store)
      ref_mem[{s.x, s.y, s.addr}] = s.data;
    else
    begin
      // reply heads back to the injecting column below the south edge
      exp_pkt = '{op: mesh_op_reply, dst_x: s.col, dst_y: `MESH_Y_W'(`MESH_Y), src_x: s.x,
                  src_y: s.y, addr: s.addr, data: ref_mem[{s.x, s.y, s.addr}]};
      exp_q.push_back(exp_pkt);
    end
    @(posedge clk_i);
    #1;
    ver_link_i[S][s.col] = '0;
  endtask

  task automatic match_reply(input int c, input mesh_packet_s pkt);
    int    idx;
    string name;
    idx  = -1;
    name = $sformatf("ver_link_o[S][%0d].pkt", c);
    for (int i = 0; i < exp_q.size(); i++)
      if (idx < 0 && exp_q[i].src_x == pkt.src_x && exp_q[i].src_y == pkt.src_y
          && exp_q[i].addr == pkt.addr)
        idx = i;
    if (idx < 0)
    begin
      errors++;
      $display("unexpected reply from tile (%0d,%0d) for address %0d on south column %0d",
               pkt.src_x, pkt.src_y, pkt.addr, c);
    end
    else
    begin
      check_eq({name, ".op"}, pkt.op, exp_q[idx].op);
      check_eq({name, ".dst_x"}, pkt.dst_x, exp_q[idx].dst_x);
      check_eq({name, ".dst_y"}, pkt.dst_y, exp_q[idx].dst_y);
      check_eq({name, ".data"}, pkt.data, exp_q[idx].data);
      check_eq("reply column", c, exp_q[idx].dst_x);
      exp_q.delete(idx);
    end
  endtask

  task automatic collect_replies();
    int got;
    int wait_cyc;
    got      = 0;
    wait_cyc = 0;
    while (got < num_loads && wait_cyc < timeout_lp)
    begin
      @(negedge clk_i);
      wait_cyc++;
      for (int c = 0; c < `MESH_X; c++)
        if (ver_link_o[S][c].v && ver_ready_i[S][c])
        begin
          match_reply(c, ver_link_o[S][c].pkt);
          got++;
          wait_cyc = 0;
        end
      for (int r = 0; r < `MESH_Y; r++)
        if (hor_link_o[E][r].v || hor_link_o[W][r].v)
        begin
          errors++;
          $display("a packet left row %0d on the east or west edge", r);
        end
      for (int c = 0; c < `MESH_X; c++)
        if (ver_link_o[N][c].v)
        begin
          errors++;
          $display("a packet left column %0d on the north edge", c);
        end
    end
    if (got < num_loads)
    begin
      errors++;
      $display("timeout: only %0d of %0d load replies arrived", got, num_loads);
    end
    // nothing more may follow the last reply
    for (int k = 0; k < 20; k++)
    begin
      @(negedge clk_i);
      for (int c = 0; c < `MESH_X; c++)
        if (ver_link_o[S][c].v)
        begin
          errors++;
          $display("extra reply on south column %0d after all loads were answered", c);
        end
    end
  endtask

  initial
  begin : ready_drive
    ver_ready_i = '1;
    hor_ready_i = '1;
    forever
    begin
      @(posedge clk_i);
      #1;
      for (int c = 0; c < `MESH_X; c++)
        ver_ready_i[S][c] = rand_ready ? 1'($random(seed)) : 1'b1;
    end
  end

  initial
  begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    hor_link_i = '0;
    ver_link_i = '0;
    errors     = 0;
    num_loads  = 0;
    timed_out  = 1'b0;
    rand_ready = 1'b0;
    for (int a = 0; a < ref_words_lp; a++)
      ref_mem[a] = '0;
    // col, op, tile x, tile y, addr, data
    stim_tab = '{
      '{1'd0, mesh_op_load,  1'd0, 2'd0, 4'd3, 16'h0000}, // never stored
      '{1'd1, mesh_op_load,  1'd1, 2'd1, 4'd7, 16'h0000},
      '{1'd0, mesh_op_store, 1'd0, 2'd0, 4'd5, 16'h1111}, // same address in four tiles
      '{1'd0, mesh_op_store, 1'd1, 2'd0, 4'd5, 16'h2222},
      '{1'd1, mesh_op_store, 1'd0, 2'd1, 4'd5, 16'h3333},
      '{1'd1, mesh_op_store, 1'd1, 2'd1, 4'd5, 16'h4444},
      '{1'd0, mesh_op_load,  1'd0, 2'd0, 4'd5, 16'h0000},
      '{1'd0, mesh_op_load,  1'd1, 2'd0, 4'd5, 16'h0000}, // cross column
      '{1'd1, mesh_op_load,  1'd0, 2'd1, 4'd5, 16'h0000},
      '{1'd1, mesh_op_load,  1'd1, 2'd1, 4'd5, 16'h0000},
      '{1'd0, mesh_op_store, 1'd0, 2'd1, 4'd9, 16'habcd},
      '{1'd0, mesh_op_load,  1'd0, 2'd1, 4'd9, 16'h0000},
      '{1'd1, mesh_op_store, 1'd1, 2'd0, 4'd2, 16'h5a5a},
      '{1'd1, mesh_op_load,  1'd1, 2'd0, 4'd2, 16'h0000},
      '{1'd0, mesh_op_load,  1'd1, 2'd1, 4'd9, 16'h0000},
      '{1'd1, mesh_op_load,  1'd1, 2'd0, 4'd2, 16'h0000}
    };
    for (int i = 0; i < num_stim_lp; i++)
      if (stim_tab[i].op == mesh_op_load)
        num_loads++;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    fork
      begin
        for (int i = 0; i < num_stim_lp && !timed_out; i++)
        begin
          rand_ready = (i >= rand_start_lp);
          @(posedge clk_i);
          #1;
          send_entry(i, stim_tab[i]);
        end
        rand_ready = 1'b0;
      end
      collect_replies();
    join
    check_eq("scoreboard entries left", exp_q.size(), 0);
    // all traffic drained, so every edge input FIFO is empty
    check_eq("hor_ready_o", hor_ready_o, {(2 * `MESH_Y){1'b1}});
    check_eq("ver_ready_o", ver_ready_o, {(2 * `MESH_X){1'b1}});
    check_eq("assertion failures", mesh_array_i.link_chk.fail_cnt, 0);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/mesh_array_chk.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_array_chk
  (
    input wire                                                         clk_i,
    input wire                                                         rst_n_i,
    input wire mesh_pkg::mesh_link_s [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0] ver_out_i,
    input wire [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0]                  ver_ready_i,
    input wire mesh_pkg::mesh_link_s [mesh_pkg::E:mesh_pkg::W][`MESH_Y-1:0] hor_out_i
  );

  timeunit 1ns;
  timeprecision 100ps;

  import mesh_pkg::*;

  logic any_v; // any edge output offering a packet
  int   fail_cnt = 0;

  always_comb
  begin
    any_v = 1'b0;
    for (int c = 0; c < `MESH_X; c++)
      any_v = any_v | ver_out_i[S][c].v | ver_out_i[N][c].v;
    for (int r = 0; r < `MESH_Y; r++)
      any_v = any_v | hor_out_i[E][r].v | hor_out_i[W][r].v;
  end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !any_v)
    else
    begin
      fail_cnt++;
      $error("edge link valid while reset is held");
    end

  for (genvar c = 0; c < `MESH_X; c++)
  begin : south_gen
    hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ver_out_i[S][c].v && !ver_ready_i[S][c]
      |=> ver_out_i[S][c].v && $stable(ver_out_i[S][c].pkt))
      else
      begin
        fail_cnt++;
        $error("south link %0d dropped or changed a packet before it was taken", c);
      end
  end

endmodule

`default_nettype wire

// ==== logic/mesh_array.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_array
  (
    input  wire clk_i,
    input  wire rst_n_i,

    // horizontal {E, W} by row
    input  wire mesh_pkg::mesh_link_s [mesh_pkg::E:mesh_pkg::W][`MESH_Y-1:0] hor_link_i,
    output logic [mesh_pkg::E:mesh_pkg::W][`MESH_Y-1:0]                      hor_ready_o,
    output mesh_pkg::mesh_link_s [mesh_pkg::E:mesh_pkg::W][`MESH_Y-1:0]      hor_link_o,
    input  wire [mesh_pkg::E:mesh_pkg::W][`MESH_Y-1:0]                       hor_ready_i,

    // vertical {S, N} by column
    input  wire mesh_pkg::mesh_link_s [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0] ver_link_i,
    output logic [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0]                      ver_ready_o,
    output mesh_pkg::mesh_link_s [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0]      ver_link_o,
    input  wire [mesh_pkg::S:mesh_pkg::N][`MESH_X-1:0]                       ver_ready_i
  );

  import mesh_pkg::*;

  mesh_link_s [`MESH_Y-1:0][`MESH_X-1:0][S:W] link_out;
  logic [`MESH_Y-1:0][`MESH_X-1:0][S:W]       ready_out;

  for (genvar r = 0; r < `MESH_Y; r++)
  begin : row_gen
    for (genvar c = 0; c < `MESH_X; c++)
    begin : col_gen
      // neighbour indices clamped at the grid edges
      localparam int cw = (c == 0) ? c : c - 1;
      localparam int ce = (c == `MESH_X - 1) ? c : c + 1;
      localparam int rn = (r == 0) ? r : r - 1;
      localparam int rs = (r == `MESH_Y - 1) ? r : r + 1;

      mesh_link_s [S:W] link_in;
      logic [S:W]       ready_in;

      assign link_in[W]  = (c == 0) ? hor_link_i[W][r] : link_out[r][cw][E];
      assign link_in[E]  = (c == `MESH_X - 1) ? hor_link_i[E][r] : link_out[r][ce][W];
      assign link_in[N]  = (r == 0) ? ver_link_i[N][c] : link_out[rn][c][S];
      assign link_in[S]  = (r == `MESH_Y - 1) ? ver_link_i[S][c] : link_out[rs][c][N];
      assign ready_in[W] = (c == 0) ? hor_ready_i[W][r] : ready_out[r][cw][E];
      assign ready_in[E] = (c == `MESH_X - 1) ? hor_ready_i[E][r] : ready_out[r][ce][W];
      assign ready_in[N] = (r == 0) ? ver_ready_i[N][c] : ready_out[rn][c][S];
      assign ready_in[S] = (r == `MESH_Y - 1) ? ver_ready_i[S][c] : ready_out[rs][c][N];

      mesh_tile tile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .my_x_i  (`MESH_X_W'(c)),
        .my_y_i  (`MESH_Y_W'(r)),
        .link_i  (link_in),
        .ready_o (ready_out[r][c]),
        .link_o  (link_out[r][c]),
        .ready_i (ready_in)
      );
    end
  end

  for (genvar r = 0; r < `MESH_Y; r++)
  begin : hor_out_gen
    assign hor_link_o[E][r]  = link_out[r][`MESH_X-1][E];
    assign hor_link_o[W][r]  = link_out[r][0][W];
    assign hor_ready_o[E][r] = ready_out[r][`MESH_X-1][E];
    assign hor_ready_o[W][r] = ready_out[r][0][W];
  end

  for (genvar c = 0; c < `MESH_X; c++)
  begin : ver_out_gen
    assign ver_link_o[S][c]  = link_out[`MESH_Y-1][c][S]; // replies leave here
    assign ver_link_o[N][c]  = link_out[0][c][N];
    assign ver_ready_o[S][c] = ready_out[`MESH_Y-1][c][S];
    assign ver_ready_o[N][c] = ready_out[0][c][N];
  end

endmodule

`default_nettype wire

// ==== logic/mesh_tile.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_tile
  (
    input  wire                                                  clk_i,
    input  wire                                                  rst_n_i,
    input  wire [`MESH_X_W-1:0]                                  my_x_i,
    input  wire [`MESH_Y_W-1:0]                                  my_y_i,
    input  wire mesh_pkg::mesh_link_s [mesh_pkg::S:mesh_pkg::W]  link_i,
    output logic [mesh_pkg::S:mesh_pkg::W]                       ready_o,
    output mesh_pkg::mesh_link_s [mesh_pkg::S:mesh_pkg::W]       link_o,
    input  wire [mesh_pkg::S:mesh_pkg::W]                        ready_i
  );

  import mesh_pkg::*;

  mesh_link_s [4:0] rtr_link_o;
  logic [4:0]       rtr_ready_o;
  mesh_link_s       bank_link_o;
  logic             bank_ready_o;

  // local port P sits at bit 0 below the four mesh directions
  mesh_router router (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .my_x_i  (my_x_i),
    .my_y_i  (my_y_i),
    .link_i  ({link_i, bank_link_o}),
    .ready_o (rtr_ready_o),
    .link_o  (rtr_link_o),
    .ready_i ({ready_i, bank_ready_o})
  );

  mesh_bank bank (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .my_x_i  (my_x_i),
    .my_y_i  (my_y_i),
    .link_i  (rtr_link_o[P]),
    .ready_o (bank_ready_o),
    .link_o  (bank_link_o),
    .ready_i (rtr_ready_o[P])
  );

  assign link_o  = rtr_link_o[S:W];
  assign ready_o = rtr_ready_o[S:W];

endmodule

`default_nettype wire

// ==== logic/mesh_bank.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_bank
  (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire [`MESH_X_W-1:0]       my_x_i,
    input  wire [`MESH_Y_W-1:0]       my_y_i,
    input  wire mesh_pkg::mesh_link_s link_i,
    output logic                      ready_o,
    output mesh_pkg::mesh_link_s      link_o,
    input  wire                       ready_i
  );

  import mesh_pkg::*;

  localparam int words_lp = 2 ** `MESH_ADDR_W;

  logic [`MESH_DATA_W-1:0] mem [words_lp];
  mesh_bank_op_s           in_op;
  mesh_bank_op_s           head;
  logic                    head_v;
  logic                    is_load;
  logic                    pop;
  logic                    reply_v_q;
  mesh_packet_s            reply_q;

  assign in_op = '{op:    link_i.pkt.op,
                   src_x: link_i.pkt.src_x,
                   src_y: link_i.pkt.src_y,
                   addr:  link_i.pkt.addr,
                   data:  link_i.pkt.data};

  mesh_fifo #(
    .payload_t (mesh_bank_op_s),
    .els_p     (`MESH_FIFO_ELS)
  ) op_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (in_op),
    .v_i     (link_i.v),
    .ready_o (ready_o),
    .data_o  (head),
    .v_o     (head_v),
    .yumi_i  (pop)
  );

  // a load waits for the reply slot to free up
  assign is_load = (head.op == mesh_op_load);
  assign pop     = head_v & (!is_load | !reply_v_q | ready_i);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int a = 0; a < words_lp; a++)
        mem[a] <= '0;
    end
    else if (pop && head.op == mesh_op_store)
      mem[head.addr] <= head.data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      reply_v_q <= 1'b0;
    else if (pop && is_load)
      reply_v_q <= 1'b1;
    else if (ready_i)
      reply_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (pop && is_load)
      reply_q <= '{op:    mesh_op_reply,
                   dst_x: head.src_x,
                   dst_y: head.src_y,
                   src_x: my_x_i,
                   src_y: my_y_i,
                   addr:  head.addr,
                   data:  mem[head.addr]};
  end

  assign link_o = '{v: reply_v_q, pkt: reply_q};

endmodule

`default_nettype wire

// ==== logic/mesh_router.sv ====
`include "mesh_defines.svh"
`default_nettype none

module mesh_router
  (
    input  wire                             clk_i,
    input  wire                             rst_n_i,
    input  wire [`MESH_X_W-1:0]             my_x_i,
    input  wire [`MESH_Y_W-1:0]             my_y_i,
    input  wire mesh_pkg::mesh_link_s [4:0] link_i,
    output logic [4:0]                      ready_o,
    output mesh_pkg::mesh_link_s [4:0]      link_o,
    input  wire [4:0]                       ready_i
  );

  import mesh_pkg::*;

  mesh_packet_s [4:0] head;
  logic [4:0]         head_v;
  logic [4:0]         yumi;
  logic [4:0][4:0]    req; // [output][input]
  logic [4:0][2:0]    sel;

  // x first, then y
  function automatic mesh_dir_e xy_route(input mesh_packet_s pkt);
    mesh_dir_e dir;
    if (pkt.dst_x > my_x_i)
      dir = E;
    else if (pkt.dst_x < my_x_i)
      dir = W;
    else if (pkt.dst_y > my_y_i)
      dir = S;
    else if (pkt.dst_y < my_y_i)
      dir = N;
    else
      dir = P;
    return dir;
  endfunction

  function automatic logic [2:0] rr_pick(input logic [4:0] r, input logic [2:0] ptr);
    logic [2:0] pick;
    logic       found;
    int         j;
    pick  = ptr;
    found = 1'b0;
    for (int k = 0; k < 5; k++)
    begin
      j = (int'(ptr) + k) % 5;
      if (!found && r[j])
      begin
        pick  = 3'(j);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < 5; i++)
  begin : in_gen
    mesh_dir_e dir;

    mesh_fifo #(
      .payload_t (mesh_packet_s),
      .els_p     (`MESH_FIFO_ELS)
    ) fifo_in (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (link_i[i].pkt),
      .v_i     (link_i[i].v),
      .ready_o (ready_o[i]),
      .data_o  (head[i]),
      .v_o     (head_v[i]),
      .yumi_i  (yumi[i])
    );

    assign dir = xy_route(head[i]);

    for (genvar o = 0; o < 5; o++)
    begin : req_gen
      assign req[o][i] = head_v[i] & (dir == mesh_dir_e'(o));
    end
  end

  for (genvar o = 0; o < 5; o++)
  begin : out_gen
    logic       lock_q;     // grant held while stalled
    logic [2:0] lock_idx_q;
    logic [2:0] rr_ptr_q;

    assign sel[o]        = lock_q ? lock_idx_q : rr_pick(req[o], rr_ptr_q);
    assign link_o[o].v   = |req[o];
    assign link_o[o].pkt = head[sel[o]];

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
      begin
        lock_q     <= 1'b0;
        lock_idx_q <= '0;
        rr_ptr_q   <= '0;
      end
      else if (link_o[o].v && ready_i[o])
      begin
        lock_q   <= 1'b0;
        rr_ptr_q <= (sel[o] == 3'd4) ? 3'd0 : sel[o] + 3'd1; // winner goes last
      end
      else if (link_o[o].v)
      begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel[o];
      end
    end
  end

  // each head requests one output, so grants never collide
  always_comb
  begin
    yumi = '0;
    for (int o = 0; o < 5; o++)
      if (link_o[o].v && ready_i[o])
        yumi[sel[o]] = 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/mesh_fifo.sv ====
`default_nettype none

module mesh_fifo
  #(
    parameter type payload_t = logic,
    parameter int  els_p     = 2
  )
  (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  wire      payload_t data_i,
    input  wire      v_i,
    output logic     ready_o,
    output payload_t data_o,
    output logic     v_o,
    input  wire      yumi_i // head consumed
  );

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  payload_t            mem [els_p];
  logic [ptr_w_lp-1:0] rd_ptr_q;
  logic [ptr_w_lp-1:0] wr_ptr_q;
  logic [cnt_w_lp-1:0] count_q;
  logic                enq;
  logic                deq;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    return (ptr == ptr_w_lp'(els_p - 1)) ? '0 : ptr + 1'b1; // wrap for any depth
  endfunction

  assign ready_o = (count_q != cnt_w_lp'(els_p));
  assign v_o     = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (deq)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({enq, deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/mesh_pkg.sv ====
`include "mesh_defines.svh"
`default_nettype none

package mesh_pkg;

  typedef enum logic [1:0] {
    mesh_op_store = 2'd0,
    mesh_op_load  = 2'd1,
    mesh_op_reply = 2'd2
  } mesh_op_e;

  // router port index with the local port first
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } mesh_dir_e;

  typedef struct packed {
    mesh_op_e                op;
    logic [`MESH_X_W-1:0]    dst_x;
    logic [`MESH_Y_W-1:0]    dst_y;
    logic [`MESH_X_W-1:0]    src_x;
    logic [`MESH_Y_W-1:0]    src_y;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } mesh_packet_s;

  typedef struct packed {
    mesh_op_e                op;
    logic [`MESH_X_W-1:0]    src_x; // reply goes back here
    logic [`MESH_Y_W-1:0]    src_y;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } mesh_bank_op_s;

  // ready travels the other way
  typedef struct packed {
    logic         v;
    mesh_packet_s pkt;
  } mesh_link_s;

endpackage

`default_nettype wire

// ==== logic/mesh_defines.svh ====
`default_nettype none

`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

// grid size in tiles
`define MESH_X 2
`define MESH_Y 2

// y needs room for the external row at MESH_Y
`define MESH_X_W 1
`define MESH_Y_W 2

`define MESH_ADDR_W 4
`define MESH_DATA_W 16

`define MESH_FIFO_ELS 2 // per router input

`endif

`default_nettype wire
